// ==== hdl/tpu_pkg.sv ====
`default_nettype none

package tpu_pkg;

        // ========================================
        // widths
        // ========================================
        localparam int DATA_W = 8;
        localparam int ACC_W  = 16;

        // ========================================
        // element types
        // ========================================
        typedef logic [DATA_W-1:0] data_t;
        typedef logic [ACC_W-1:0]  acc_t;

        // controller phases
        typedef enum logic [2:0] {
                st_idle,
                st_load_compute,
                st_settle,
                st_drain,
                st_finish
        } tpu_state_e;

endpackage

`default_nettype wire

// ==== hdl/array_feed_if.sv ====
`default_nettype none

interface array_feed_if #(
        parameter int N = 4
);
        import tpu_pkg::*;

        // skewed operands at the west and north edges of the grid
        data_t [N-1:0] a_edge;
        data_t [N-1:0] b_edge;

        // advance one wave, or zero everything (clear wins)
        logic          step;
        logic          clear;

        modport feeder (output a_edge, output b_edge, input step, input clear);
        modport ctrl   (output step, output clear);
        modport array  (input a_edge, input b_edge, input step, input clear);

endinterface

`default_nettype wire

// ==== hdl/tpu_ctrl.sv ====
`default_nettype none

module tpu_ctrl #(
        parameter int N = 4
) (
        input  logic                 clk,
        input  logic                 rst_n,
        input  logic                 in_valid,
        input  logic                 out_ready,
        output logic                 in_ready,
        output logic                 done,
        output logic                 wr,
        output logic [$clog2(N)-1:0] row_sel,
        array_feed_if.ctrl           feed
);
        import tpu_pkg::*;

        localparam int STEPS = 3 * N;
        localparam int CNT_W = $clog2(STEPS + 1);

        tpu_state_e       state;
        tpu_state_e       state_nxt;
        logic [CNT_W-1:0] count;
        logic [CNT_W-1:0] count_nxt;

        // ========================================
        // phase sequencing
        // ========================================
        always_comb begin
                state_nxt = state;
                case (state)
                        st_idle: begin
                                if (in_valid)
                                        state_nxt = st_load_compute;
                        end
                        st_load_compute: begin
                                if (count == CNT_W'(STEPS))
                                        state_nxt = st_settle;
                        end
                        st_settle: begin
                                state_nxt = st_drain;
                        end
                        st_drain: begin
                                // last row leaves on this handshake
                                if (out_ready && count == CNT_W'(N - 1))
                                        state_nxt = st_finish;
                        end
                        st_finish: begin
                                state_nxt = st_idle;
                        end
                        default: begin
                                state_nxt = st_idle;
                        end
                endcase
        end

        // steps while computing, consumed rows while draining
        always_comb begin
                case (state_nxt)
                        st_load_compute: count_nxt = count + 1'b1;
                        st_drain: begin
                                if (state == st_drain && out_ready)
                                        count_nxt = count + 1'b1;
                                else
                                        count_nxt = count;
                        end
                        default: count_nxt = '0;
                endcase
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state <= st_idle;
                        count <= '0;
                        done  <= 1'b0;
                end else begin
                        state <= state_nxt;
                        count <= count_nxt;
                        done  <= (state_nxt == st_finish);
                end
        end

        // ========================================
        // outputs
        // ========================================
        // first N beats of a job, counting the start beat
        assign in_ready   = (state == st_idle) ||
                            (state == st_load_compute && count < CNT_W'(N));
        assign wr         = (state_nxt == st_drain);
        assign row_sel    = count_nxt[$clog2(N)-1:0];
        assign feed.step  = (state_nxt == st_load_compute);
        assign feed.clear = (state_nxt == st_idle);

endmodule

`default_nettype wire

// ==== hdl/skew_buffer.sv ====
`default_nettype none

module skew_buffer #(
        parameter int N = 4
) (
        input  logic                          clk,
        input  logic                          rst_n,
        input  logic [N*tpu_pkg::DATA_W-1:0]  a,
        input  logic [N*tpu_pkg::DATA_W-1:0]  b,
        input  logic                          fill,
        array_feed_if.feeder                  feed
);
        import tpu_pkg::*;

        // side 0 carries A rows, side 1 carries B columns
        data_t [N-1:0] elem     [2];
        data_t [N-1:0] edge_val [2];

        // element 0 sits in the top byte
        always_comb begin
                for (int i = 0; i < N; i++) begin
                        elem[0][i] = a[(N-1-i)*DATA_W +: DATA_W];
                        elem[1][i] = b[(N-1-i)*DATA_W +: DATA_W];
                end
        end

        // ========================================
        // triangular delay lines
        // ========================================
        for (genvar s = 0; s < 2; s++) begin : g_side
                for (genvar i = 0; i < N; i++) begin : g_line
                        data_t head;

                        // zeros once the job's beats are in
                        assign head = fill ? elem[s][i] : '0;

                        if (i == 0) begin : g_pass
                                assign edge_val[s][i] = head;
                        end else begin : g_delay
                                data_t taps [i];

                                always_ff @(posedge clk or negedge rst_n) begin
                                        if (!rst_n) begin
                                                for (int d = 0; d < i; d++)
                                                        taps[d] <= '0;
                                        end else if (feed.clear) begin
                                                for (int d = 0; d < i; d++)
                                                        taps[d] <= '0;
                                        end else if (feed.step) begin
                                                taps[0] <= head;
                                                for (int d = 1; d < i; d++)
                                                        taps[d] <= taps[d-1];
                                        end
                                end

                                assign edge_val[s][i] = taps[i-1];
                        end
                end
        end

        assign feed.a_edge = edge_val[0];
        assign feed.b_edge = edge_val[1];

endmodule

`default_nettype wire

// ==== hdl/pe_array.sv ====
`default_nettype none

module pe_array #(
        parameter int N = 4
) (
        input  logic                          clk,
        input  logic                          rst_n,
        array_feed_if.array                   feed,
        output tpu_pkg::acc_t [N-1:0][N-1:0]  acc
);
        import tpu_pkg::*;

        // registered operands, visible to the east and south neighbours
        data_t a_pass [N][N];
        data_t b_pass [N][N];

        // ========================================
        // cell grid
        // ========================================
        for (genvar i = 0; i < N; i++) begin : g_row
                for (genvar j = 0; j < N; j++) begin : g_col
                        data_t               a_in;
                        data_t               b_in;
                        data_t               a_q;
                        data_t               b_q;
                        acc_t                sum_q;
                        logic [2*DATA_W-1:0] prod;

                        if (j == 0) begin : g_west_edge
                                assign a_in = feed.a_edge[i];
                        end else begin : g_west_cell
                                assign a_in = a_pass[i][j-1];
                        end

                        if (i == 0) begin : g_north_edge
                                assign b_in = feed.b_edge[j];
                        end else begin : g_north_cell
                                assign b_in = b_pass[i-1][j];
                        end

                        // exact product of the pair held in this cell
                        assign prod = a_q * b_q;

                        always_ff @(posedge clk or negedge rst_n) begin
                                if (!rst_n) begin
                                        a_q   <= '0;
                                        b_q   <= '0;
                                        sum_q <= '0;
                                end else if (feed.clear) begin
                                        a_q   <= '0;
                                        b_q   <= '0;
                                        sum_q <= '0;
                                end else if (feed.step) begin
                                        a_q   <= a_in;
                                        b_q   <= b_in;
                                        // wraps at 2^ACC_W
                                        sum_q <= sum_q + acc_t'(prod);
                                end
                        end

                        assign a_pass[i][j] = a_q;
                        assign b_pass[i][j] = b_q;
                        assign acc[i][j]    = sum_q;
                end
        end

endmodule

`default_nettype wire

// ==== hdl/result_drain.sv ====
`default_nettype none

module result_drain #(
        parameter int N = 4
) (
        input  logic                          clk,
        input  logic                          rst_n,
        input  tpu_pkg::acc_t [N-1:0][N-1:0]  acc,
        input  logic                          wr,
        input  logic [$clog2(N)-1:0]          row_sel,
        output logic [N*tpu_pkg::ACC_W-1:0]   out,
        output logic                          out_valid
);
        import tpu_pkg::*;

        logic [N*ACC_W-1:0] row_word;

        // ========================================
        // row select
        // ========================================
        // column 0 goes to the top of the word
        always_comb begin
                for (int j = 0; j < N; j++) begin
                        row_word[(N-1-j)*ACC_W +: ACC_W] = acc[row_sel][j];
                end
        end

        // ========================================
        // output register
        // ========================================
        // reloading the same row under back-pressure keeps out steady,
        // the grid does not step while draining
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        out       <= '0;
                        out_valid <= 1'b0;
                end else if (wr) begin
                        out       <= row_word;
                        out_valid <= 1'b1;
                end else begin
                        out       <= '0;
                        out_valid <= 1'b0;
                end
        end

endmodule

`default_nettype wire

// ==== hdl/tpu.sv ====
`default_nettype none

module tpu #(
        parameter int N = 4
) (
        input  logic                          clk,
        input  logic                          rst_n,
        input  logic                          in_valid,
        input  logic                          out_ready,
        input  logic [N*tpu_pkg::DATA_W-1:0]  a,
        input  logic [N*tpu_pkg::DATA_W-1:0]  b,
        output logic [N*tpu_pkg::ACC_W-1:0]   out,
        output logic                          in_ready,
        output logic                          out_valid,
        output logic                          done
);
        import tpu_pkg::*;

        logic                 wr;
        logic [$clog2(N)-1:0] row_sel;
        acc_t [N-1:0][N-1:0]  acc;

        array_feed_if #(.N(N)) feed ();

        // ========================================
        // control
        // ========================================
        tpu_ctrl #(
                .N         (N)
        ) u_ctrl (
                .clk       (clk),
                .rst_n     (rst_n),
                .in_valid  (in_valid),
                .out_ready (out_ready),
                .in_ready  (in_ready),
                .done      (done),
                .wr        (wr),
                .row_sel   (row_sel),
                .feed      (feed.ctrl)
        );

        // ========================================
        // datapath
        // ========================================
        // input beats are taken while in_ready is high
        skew_buffer #(
                .N         (N)
        ) u_skew (
                .clk       (clk),
                .rst_n     (rst_n),
                .a         (a),
                .b         (b),
                .fill      (in_ready),
                .feed      (feed.feeder)
        );

        pe_array #(
                .N         (N)
        ) u_array (
                .clk       (clk),
                .rst_n     (rst_n),
                .feed      (feed.array),
                .acc       (acc)
        );

        result_drain #(
                .N         (N)
        ) u_drain (
                .clk       (clk),
                .rst_n     (rst_n),
                .acc       (acc),
                .wr        (wr),
                .row_sel   (row_sel),
                .out       (out),
                .out_valid (out_valid)
        );

endmodule

`default_nettype wire

// ==== sim/tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen #(
        parameter int PERIOD       = 20,
        parameter int RESET_CYCLES = 2
) (
        output logic clk,
        output logic rst_n
);
        initial begin
                clk = 1'b0;
                forever #(PERIOD / 2) clk = ~clk;
        end

        // release well clear of the edge and of the input drive point
        initial begin
                rst_n = 1'b0;
                repeat (RESET_CYCLES) @(posedge clk);
                #(PERIOD / 4);
                rst_n = 1'b1;
        end

endmodule

`default_nettype wire

// ==== sim/tpu_assert.sv ====
`default_nettype none

module tpu_assert #(
        parameter int N = 4
) (
        input logic                        clk,
        input logic                        rst_n,
        input logic                        in_ready,
        input logic                        out_valid,
        input logic                        out_ready,
        input logic                        done,
        input logic [N*tpu_pkg::ACC_W-1:0] out
);
        // input and output phases never overlap
        a_phase_excl: assert property (@(posedge clk) disable iff (!rst_n)
                !(out_valid && in_ready))
                else $error("out_valid and in_ready high together");

        a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
                done |=> !done)
                else $error("done held longer than one cycle");

        // stalled row stays put
        a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
                (out_valid && !out_ready) |=> (out_valid && $stable(out)))
                else $error("out changed while out_ready was low");

endmodule

bind tpu tpu_assert #(.N(N)) u_assert (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .done      (done),
        .out       (out)
);

`default_nettype wire

// ==== sim/tpu_tb.sv ====
`default_nettype none

module tpu_tb;
        import tpu_pkg::*;

        localparam int N         = 4;
        localparam int JOBS      = 20;
        localparam int TIMEOUT   = 500;
        localparam int DRIVE_DLY = 2;

        logic                clk;
        logic                rst_n;
        logic                in_valid;
        logic                out_ready;
        logic [N*DATA_W-1:0] a;
        logic [N*DATA_W-1:0] b;
        logic [N*ACC_W-1:0]  out;
        logic                in_ready;
        logic                out_valid;
        logic                done;

        data_t               mat_a [N][N];
        data_t               mat_b [N][N];
        acc_t [N-1:0]        expected [N];
        logic [31:0]         rng;
        int                  mismatch_count;
        int                  flag_errors;
        int                  timeout_count;
        logic                aborted;

        tb_clk_gen #(.PERIOD(20), .RESET_CYCLES(2)) u_clk_gen (.clk(clk), .rst_n(rst_n));

        tpu #(.N(N)) tpu_i (.*);

        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] s;
                s = x ^ (x << 13);
                s = s ^ (s >> 17);
                s = s ^ (s << 5);
                return s;
        endfunction

        function automatic data_t rand_byte();
                rng = xorshift32(rng);
                return rng[15:8];
        endfunction

        task automatic tick();
                @(posedge clk);
                #DRIVE_DLY;
        endtask

        // ========================================
        // reference model
        // ========================================
        task automatic make_job(input logic saturate);
                int total;
                for (int i = 0; i < N; i++) begin
                        for (int j = 0; j < N; j++) begin
                                if (saturate) begin
                                        mat_a[i][j] = 8'hff;
                                        mat_b[i][j] = 8'hff;
                                end else begin
                                        mat_a[i][j] = rand_byte();
                                        mat_b[i][j] = rand_byte();
                                end
                        end
                end
                for (int r = 0; r < N; r++) begin
                        for (int j = 0; j < N; j++) begin
                                total = 0;
                                for (int k = 0; k < N; k++)
                                        total += int'(mat_a[r][k]) * int'(mat_b[k][j]);
                                expected[r][j] = acc_t'(total % 65536);
                        end
                end
        endtask

        // beat k holds column k of A and row k of B with element 0 on top
        task automatic drive_beat(input int k);
                for (int i = 0; i < N; i++) begin
                        a[(N-1-i)*DATA_W +: DATA_W] = mat_a[i][k];
                        b[(N-1-i)*DATA_W +: DATA_W] = mat_b[k][i];
                end
        endtask

        // ========================================
        // compare tasks
        // ========================================
        task automatic check_row(input int row, input acc_t [N-1:0] exp_row);
                acc_t got;
                for (int j = 0; j < N; j++) begin
                        got = out[(N-1-j)*ACC_W +: ACC_W];
                        if (got !== exp_row[j]) begin
                                $display("Mismatch out row %0d col %0d: got %h expected %h",
                                         row, j, got, exp_row[j]);
                                mismatch_count++;
                        end
                end
        endtask

        task automatic check_flag(input string name, input logic got, input logic exp);
                if (got !== exp) begin
                        $display("Mismatch %s: got %h expected %h", name, got, exp);
                        flag_errors++;
                end
        endtask

        task automatic report_timeout(input string what);
                $display("Timed out waiting for %s", what);
                timeout_count++;
                aborted = 1'b1;
        endtask

        task automatic run_job(input logic saturate, input logic stall);
                int   row;
                int   cycles;
                logic started;
                if (aborted)
                        return;
                make_job(saturate);
                cycles = 0;
                while (in_ready !== 1'b1 && cycles < TIMEOUT) begin
                        tick();
                        cycles++;
                end
                if (in_ready !== 1'b1) begin
                        report_timeout("in_ready before a job");
                        return;
                end
                // start beat and then the rest back to back
                in_valid = 1'b1;
                drive_beat(0);
                tick();
                in_valid = 1'b0;
                for (int k = 1; k < N; k++) begin
                        check_flag("in_ready", in_ready, 1'b1);
                        check_flag("done", done, 1'b0);
                        drive_beat(k);
                        tick();
                end
                check_flag("in_ready", in_ready, 1'b0);
                // bus noise that must not reach the grid
                for (int i = 0; i < N; i++) begin
                        a[i*DATA_W +: DATA_W] = rand_byte();
                        b[i*DATA_W +: DATA_W] = rand_byte();
                end
                row = 0;
                started = 1'b0;
                cycles = 0;
                while (row < N && cycles < TIMEOUT) begin
                        check_flag("done", done, 1'b0);
                        check_flag("in_ready", in_ready, 1'b0);
                        if (out_valid === 1'b1) begin
                                started = 1'b1;
                                check_row(row, expected[row]);
                        end else if (started) begin
                                check_flag("out_valid", out_valid, 1'b1);
                        end
                        out_ready = stall ? (rand_byte() < 8'd150) : 1'b1;
                        if (out_valid === 1'b1 && out_ready)
                                row++;
                        tick();
                        cycles++;
                end
                if (row < N) begin
                        report_timeout("all result rows");
                        return;
                end
                // one cycle after the last row was taken
                check_flag("done", done, 1'b1);
                check_flag("out_valid", out_valid, 1'b0);
                tick();
                check_flag("done", done, 1'b0);
                check_flag("in_ready", in_ready, 1'b1);
        endtask

        always @(negedge clk) begin
                if (rst_n === 1'b1 && out_valid === 1'b1 && in_ready === 1'b1) begin
                        $display("out_valid and in_ready were high in the same cycle");
                        flag_errors++;
                end
        end

        initial begin
                int cycles;
                rng = 32'd67;
                mismatch_count = 0;
                flag_errors = 0;
                timeout_count = 0;
                aborted = 1'b0;
                in_valid = 1'b0;
                out_ready = 1'b0;
                a = '0;
                b = '0;
                cycles = 0;
                while (rst_n !== 1'b1 && cycles < TIMEOUT) begin
                        tick();
                        cycles++;
                end
                if (rst_n !== 1'b1)
                        report_timeout("reset release");
                check_flag("in_ready", in_ready, 1'b1);
                check_flag("out_valid", out_valid, 1'b0);
                check_flag("done", done, 1'b0);
                check_row(0, '0);
                // out_ready held high for the first half and stalled at random after
                for (int n = 0; n < JOBS; n++)
                        run_job(1'b0, n >= JOBS / 2);
                // all operands at 255 so every sum wraps
                run_job(1'b1, 1'b1);
                run_job(1'b0, 1'b1);
                $display("errors: %0d mismatches, %0d flag errors, %0d timeouts",
                         mismatch_count, flag_errors, timeout_count);
                if (mismatch_count + flag_errors + timeout_count == 0) begin
                        $display("STATUS: PASS");
                end else begin
                        $display("STATUS: FAIL");
                end
                $finish;
        end

endmodule

`default_nettype wire

// ==== sources.f ====
hdl/tpu_pkg.sv
hdl/array_feed_if.sv
hdl/tpu_ctrl.sv
hdl/skew_buffer.sv
hdl/pe_array.sv
hdl/result_drain.sv
hdl/tpu.sv
sim/tb_clk_gen.sv
sim/tpu_assert.sv
sim/tpu_tb.sv
